// File: dcache_consts.svh
//------------------
// cache geometry and address layout for the data cache
// include before using any DC_ macro; the package pulls it in too
//------------------
`ifndef DCACHE_CONSTS_SVH
`define DCACHE_CONSTS_SVH

// 2 ways x 8 sets, two words per block
`define DC_WAYS      2
`define DC_SETS      8
`define DC_WORDS     2

// field widths
`define DC_TAG_W     26
`define DC_IDX_W     3

// address field positions
// [31:6] tag, [5:3] set, [2] word, [1:0] byte
`define DC_WORD_LSB  2
`define DC_IDX_LSB   3
`define DC_TAG_LSB   6

// hits minus misses lands here at the end of a flush
`define DC_STAT_ADDR 32'h0000_3100

`endif

// File: dcache_pkg.sv
//------------------
// types shared by the cache blocks and the testbench
// refer to them as dcache_pkg::name
//------------------
`include "dcache_consts.svh"

package dcache_pkg;

	typedef logic [31:0] word_t;
	typedef logic [`DC_TAG_W-1:0] tag_t;
	typedef logic [`DC_IDX_W-1:0] idx_t;
	typedef logic way_t;

	// processor request, held until hit
	typedef struct packed {
		logic ren;
		logic wen;
		word_t addr;
		word_t wdata;
	} cpu_req_t;

	typedef struct packed {
		logic hit;
		word_t rdata;
	} cpu_rsp_t;

	// one word per transfer, completes when dwait is low
	typedef struct packed {
		logic ren;
		logic wen;
		word_t addr;
		word_t store;
	} mem_req_t;

	// one storage update per cycle from the controller
	typedef struct packed {
		logic wr;
		logic fill;
		logic dirty_set;
		logic dirty_clr;
		logic inval;
		way_t way;
		idx_t idx;
		logic word;
		word_t data;
		tag_t tag;
		logic touch; // lru moves to the other way
	} line_op_t;

	typedef enum logic [3:0] {
		IDLE,
		WBACK1,
		WBACK2,
		FILL1,
		FILL2,
		FLUSH_RD,
		FLUSH_WR0,
		FLUSH_WR1,
		STAT,
		DONE
	} ctrl_state_t;

endpackage

// File: dcache_ways.sv
//------------------
// block storage for both ways with lookup, lru and victim choice
// all results are combinational on addr and the scan pointer
//------------------
`include "dcache_consts.svh"

module dcache_ways (
	input logic CLK,
	input logic nRST,
	input dcache_pkg::word_t addr,
	input dcache_pkg::line_op_t op,
	input dcache_pkg::idx_t scan_idx,
	input dcache_pkg::way_t scan_way,
	output logic hit,
	output dcache_pkg::way_t hit_way,
	output dcache_pkg::word_t rdata,
	output dcache_pkg::way_t victim,
	output logic victim_dirty,
	output dcache_pkg::tag_t victim_tag,
	output dcache_pkg::word_t blk_word0,
	output dcache_pkg::word_t blk_word1,
	output logic scan_dirty,
	output dcache_pkg::tag_t scan_tag,
	output dcache_pkg::word_t scan_word0,
	output dcache_pkg::word_t scan_word1
);

	// control bits
	logic [`DC_WAYS-1:0][`DC_SETS-1:0] valid;
	logic [`DC_WAYS-1:0][`DC_SETS-1:0] dirty;
	logic [`DC_SETS-1:0] lru; // way to replace next

	// payload
	dcache_pkg::tag_t tags [`DC_WAYS][`DC_SETS];
	dcache_pkg::word_t data [`DC_WAYS][`DC_SETS][`DC_WORDS];

	dcache_pkg::tag_t tag;
	dcache_pkg::idx_t idx;
	logic wsel;
	logic hit0, hit1;

	assign tag = addr[31:`DC_TAG_LSB];
	assign idx = addr[`DC_TAG_LSB-1:`DC_IDX_LSB];
	assign wsel = addr[`DC_WORD_LSB];

	// tag compare
	assign hit0 = valid[0][idx] && (tags[0][idx] == tag);
	assign hit1 = valid[1][idx] && (tags[1][idx] == tag);
	assign hit = hit0 | hit1;
	assign hit_way = hit1;
	assign rdata = data[hit_way][idx][wsel];

	// empty way first, else the lru one
	always_comb begin
		if (!valid[0][idx]) begin
			victim = 1'b0;
		end else if (!valid[1][idx]) begin
			victim = 1'b1;
		end else begin
			victim = lru[idx];
		end
	end

	assign victim_dirty = valid[victim][idx] & dirty[victim][idx];
	assign victim_tag = tags[victim][idx];
	assign blk_word0 = data[victim][idx][0];
	assign blk_word1 = data[victim][idx][1];

	// flush scan port
	assign scan_dirty = valid[scan_way][scan_idx] & dirty[scan_way][scan_idx];
	assign scan_tag = tags[scan_way][scan_idx];
	assign scan_word0 = data[scan_way][scan_idx][0];
	assign scan_word1 = data[scan_way][scan_idx][1];

	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			valid <= '0;
			dirty <= '0;
			lru <= '0;
		end else begin
			if (op.fill) begin
				valid[op.way][op.idx] <= 1'b1;
			end
			if (op.inval) begin
				valid[op.way][op.idx] <= 1'b0;
			end
			if (op.dirty_set) begin
				dirty[op.way][op.idx] <= 1'b1;
			end else if (op.dirty_clr) begin
				dirty[op.way][op.idx] <= 1'b0;
			end
			if (op.touch) begin
				lru[op.idx] <= ~op.way;
			end
		end
	end

	always_ff @(posedge CLK) begin
		if (op.fill) begin
			tags[op.way][op.idx] <= op.tag;
		end
		if (op.wr) begin
			data[op.way][op.idx][op.word] <= op.data;
		end
	end

endmodule

// File: dcache_ctrl.sv
//------------------
// miss, write-back and flush sequencing for the data cache
// drives one line op per cycle into the ways and one memory word at a time
//------------------
`include "dcache_consts.svh"

module dcache_ctrl (
	input logic CLK,
	input logic nRST,
	input dcache_pkg::cpu_req_t req,
	input logic halt,
	input logic hit,
	input dcache_pkg::way_t hit_way,
	input dcache_pkg::word_t rdata,
	input dcache_pkg::way_t victim,
	input logic victim_dirty,
	input dcache_pkg::tag_t victim_tag,
	input dcache_pkg::word_t blk_word0,
	input dcache_pkg::word_t blk_word1,
	input logic scan_dirty,
	input dcache_pkg::tag_t scan_tag,
	input dcache_pkg::word_t scan_word0,
	input dcache_pkg::word_t scan_word1,
	input logic dwait,
	input dcache_pkg::word_t dload,
	output dcache_pkg::cpu_rsp_t rsp,
	output dcache_pkg::line_op_t op,
	output dcache_pkg::idx_t scan_idx,
	output dcache_pkg::way_t scan_way,
	output dcache_pkg::mem_req_t mem,
	output logic flushed
);

	dcache_pkg::ctrl_state_t state, n_state;
	dcache_pkg::way_t miss_way, n_miss_way;
	logic [`DC_IDX_W:0] scan_cnt, n_scan_cnt; // {set, way}
	dcache_pkg::word_t hit_cnt, n_hit_cnt;
	dcache_pkg::word_t miss_cnt, n_miss_cnt;

	dcache_pkg::tag_t req_tag;
	dcache_pkg::idx_t req_idx;
	logic req_word;
	logic access;
	logic scan_last;

	function automatic dcache_pkg::word_t line_addr(
		input dcache_pkg::tag_t t,
		input dcache_pkg::idx_t i,
		input logic w
	);
		return {t, i, w, 2'b00};
	endfunction

	assign req_tag = req.addr[31:`DC_TAG_LSB];
	assign req_idx = req.addr[`DC_TAG_LSB-1:`DC_IDX_LSB];
	assign req_word = req.addr[`DC_WORD_LSB];
	assign access = req.ren | req.wen;

	// way-major inside each set
	assign scan_idx = scan_cnt[`DC_IDX_W:1];
	assign scan_way = scan_cnt[0];
	assign scan_last = (scan_cnt == (`DC_WAYS * `DC_SETS - 1));

	assign flushed = (state == dcache_pkg::DONE);

	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			state <= dcache_pkg::IDLE;
			miss_way <= 1'b0;
			scan_cnt <= '0;
			hit_cnt <= '0;
			miss_cnt <= '0;
		end else begin
			state <= n_state;
			miss_way <= n_miss_way;
			scan_cnt <= n_scan_cnt;
			hit_cnt <= n_hit_cnt;
			miss_cnt <= n_miss_cnt;
		end
	end

	always_comb begin
		n_state = state;
		n_miss_way = miss_way;
		n_scan_cnt = scan_cnt;
		n_hit_cnt = hit_cnt;
		n_miss_cnt = miss_cnt;
		rsp.hit = 1'b0;
		rsp.rdata = rdata;
		mem = '0;
		op = '0;
		op.idx = req_idx;
		op.tag = req_tag;

		case (state)
			dcache_pkg::IDLE: begin
				if (access) begin
					if (hit) begin
						rsp.hit = 1'b1;
						n_hit_cnt = hit_cnt + 32'd1;
						op.way = hit_way;
						op.word = req_word;
						op.data = req.wdata;
						op.wr = req.wen;
						op.dirty_set = req.wen;
						op.touch = 1'b1;
					end else begin
						n_miss_way = victim; // victim moves once the fill starts
						n_state = victim_dirty ? dcache_pkg::WBACK1 : dcache_pkg::FILL1;
					end
				end else if (halt) begin
					n_scan_cnt = '0;
					n_state = dcache_pkg::FLUSH_RD;
				end
			end
			dcache_pkg::WBACK1: begin
				mem.wen = 1'b1;
				mem.addr = line_addr(victim_tag, req_idx, 1'b0);
				mem.store = blk_word0;
				if (!dwait) begin
					n_state = dcache_pkg::WBACK2;
				end
			end
			dcache_pkg::WBACK2: begin
				mem.wen = 1'b1;
				mem.addr = line_addr(victim_tag, req_idx, 1'b1);
				mem.store = blk_word1;
				if (!dwait) begin
					n_state = dcache_pkg::FILL1;
				end
			end
			dcache_pkg::FILL1: begin
				// requested word first
				mem.ren = 1'b1;
				mem.addr = line_addr(req_tag, req_idx, req_word);
				if (!dwait) begin
					op.way = miss_way;
					op.word = req_word;
					op.data = req.wen ? req.wdata : dload;
					op.wr = 1'b1;
					op.fill = 1'b1;
					op.dirty_clr = 1'b1;
					n_state = dcache_pkg::FILL2;
				end
			end
			dcache_pkg::FILL2: begin
				mem.ren = 1'b1;
				mem.addr = line_addr(req_tag, req_idx, ~req_word);
				if (!dwait) begin
					op.way = miss_way;
					op.word = ~req_word;
					op.data = dload;
					op.wr = 1'b1;
					op.dirty_set = req.wen; // store lands as a dirty line
					op.touch = 1'b1;
					rsp.hit = 1'b1;
					n_miss_cnt = miss_cnt + 32'd1;
					n_state = dcache_pkg::IDLE;
				end
			end
			dcache_pkg::FLUSH_RD: begin
				if (scan_dirty) begin
					n_state = dcache_pkg::FLUSH_WR0;
				end else if (scan_last) begin
					n_state = dcache_pkg::STAT;
				end else begin
					n_scan_cnt = scan_cnt + 1'b1;
				end
			end
			dcache_pkg::FLUSH_WR0: begin
				mem.wen = 1'b1;
				mem.addr = line_addr(scan_tag, scan_idx, 1'b0);
				mem.store = scan_word0;
				if (!dwait) begin
					n_state = dcache_pkg::FLUSH_WR1;
				end
			end
			dcache_pkg::FLUSH_WR1: begin
				mem.wen = 1'b1;
				mem.addr = line_addr(scan_tag, scan_idx, 1'b1);
				mem.store = scan_word1;
				if (!dwait) begin
					op.way = scan_way;
					op.idx = scan_idx;
					op.inval = 1'b1;
					op.dirty_clr = 1'b1;
					if (scan_last) begin
						n_state = dcache_pkg::STAT;
					end else begin
						n_scan_cnt = scan_cnt + 1'b1;
						n_state = dcache_pkg::FLUSH_RD;
					end
				end
			end
			dcache_pkg::STAT: begin
				mem.wen = 1'b1;
				mem.addr = `DC_STAT_ADDR;
				mem.store = hit_cnt - miss_cnt;
				if (!dwait) begin
					n_state = dcache_pkg::DONE;
				end
			end
			dcache_pkg::DONE: begin
				n_state = dcache_pkg::DONE; // held until reset
			end
			default: begin
				n_state = dcache_pkg::IDLE;
			end
		endcase
	end

endmodule

// File: dcache.sv
//------------------
// 2-way write-back data cache between the processor port and memory
//------------------
module dcache (
	input logic CLK,
	input logic nRST,
	input dcache_pkg::cpu_req_t req,
	output dcache_pkg::cpu_rsp_t rsp,
	input logic halt,
	output logic flushed,
	output dcache_pkg::mem_req_t mem,
	input logic dwait,
	input dcache_pkg::word_t dload
);

	dcache_pkg::line_op_t op;
	dcache_pkg::idx_t scan_idx;
	dcache_pkg::way_t scan_way;

	// lookup results
	logic hit;
	dcache_pkg::way_t hit_way;
	dcache_pkg::word_t rdata;
	dcache_pkg::way_t victim;
	logic victim_dirty;
	dcache_pkg::tag_t victim_tag;
	dcache_pkg::word_t blk_word0, blk_word1;
	logic scan_dirty;
	dcache_pkg::tag_t scan_tag;
	dcache_pkg::word_t scan_word0, scan_word1;

	dcache_ways i_ways (
		.CLK(CLK),
		.nRST(nRST),
		.addr(req.addr),
		.op(op),
		.scan_idx(scan_idx),
		.scan_way(scan_way),
		.hit(hit),
		.hit_way(hit_way),
		.rdata(rdata),
		.victim(victim),
		.victim_dirty(victim_dirty),
		.victim_tag(victim_tag),
		.blk_word0(blk_word0),
		.blk_word1(blk_word1),
		.scan_dirty(scan_dirty),
		.scan_tag(scan_tag),
		.scan_word0(scan_word0),
		.scan_word1(scan_word1)
	);

	dcache_ctrl i_ctrl (
		.CLK(CLK),
		.nRST(nRST),
		.req(req),
		.halt(halt),
		.hit(hit),
		.hit_way(hit_way),
		.rdata(rdata),
		.victim(victim),
		.victim_dirty(victim_dirty),
		.victim_tag(victim_tag),
		.blk_word0(blk_word0),
		.blk_word1(blk_word1),
		.scan_dirty(scan_dirty),
		.scan_tag(scan_tag),
		.scan_word0(scan_word0),
		.scan_word1(scan_word1),
		.dwait(dwait),
		.dload(dload),
		.rsp(rsp),
		.op(op),
		.scan_idx(scan_idx),
		.scan_way(scan_way),
		.mem(mem),
		.flushed(flushed)
	);

endmodule

// File: tb_dcache_mem.sv
//--------------------
// word-addressed memory model for the cache testbench
// preloaded with address xor FILL_KEY
// adds 0 to 3 wait cycles per word
//--------------------
module tb_dcache_mem #(
	parameter logic [31:0] FILL_KEY = 32'h0
) (
	input logic CLK,
	input logic nRST,
	input dcache_pkg::mem_req_t mem,
	output logic dwait,
	output dcache_pkg::word_t dload
);

	dcache_pkg::word_t words [4096]; // 16 KB of byte space
	logic [31:0] rng;
	logic [1:0] wait_left;
	logic active;
	logic [11:0] widx;

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	assign active = mem.ren | mem.wen;
	assign widx = mem.addr[13:2];
	assign dwait = active && (wait_left != 2'd0);
	assign dload = words[widx]; // valid in the completing cycle

	initial begin
		for (int i = 0; i < 4096; i++) begin
			words[i] = (i * 4) ^ FILL_KEY;
		end
	end

	// wait count for the next word is drawn as each word completes
	always @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			rng <= 32'd16508;
			wait_left <= 2'd0;
		end else if (active) begin
			if (wait_left != 2'd0) begin
				wait_left <= wait_left - 2'd1;
			end else begin
				rng <= xorshift32(rng);
				wait_left <= rng[1:0];
			end
		end
	end

	always @(posedge CLK) begin
		if (active && !dwait && mem.wen) begin
			words[widx] <= mem.store;
		end
	end

endmodule

// File: tb_dcache.sv
//--------------------
// testbench for the data cache
// directed and random accesses against a reference model
// followed by a flush and a check of memory
//--------------------
`include "dcache_consts.svh"

module tb_dcache;

	localparam logic [31:0] FILL_KEY = 32'h5a3c_96e1;
	localparam int N_ACCESS = 316; // 16 directed + 300 random
	localparam int CYCLE_LIMIT = 40 * N_ACCESS + 200;

	typedef struct packed {
		logic read;
		logic hit;
		dcache_pkg::word_t data;
	} expect_t;

	logic CLK = 1'b0;
	logic nRST;
	dcache_pkg::cpu_req_t req;
	dcache_pkg::cpu_rsp_t rsp;
	logic halt;
	logic flushed;
	dcache_pkg::mem_req_t mem;
	logic dwait;
	dcache_pkg::word_t dload;

	// reference tags, valid and lru bits and the memory image
	logic ref_valid [`DC_WAYS][`DC_SETS];
	dcache_pkg::tag_t ref_tag [`DC_WAYS][`DC_SETS];
	logic ref_lru [`DC_SETS];
	dcache_pkg::word_t ref_img [4096];
	dcache_pkg::word_t ref_hits = '0;
	dcache_pkg::word_t ref_misses = '0;

	expect_t exp_q [$];
	string test_name = "reset";
	int errors = 0;
	int checks = 0;
	int waited = 0;
	int cycles = 0;
	logic [31:0] rng;

	always #10 CLK = ~CLK;

	dcache i_dut (
		.CLK(CLK),
		.nRST(nRST),
		.req(req),
		.rsp(rsp),
		.halt(halt),
		.flushed(flushed),
		.mem(mem),
		.dwait(dwait),
		.dload(dload)
	);

	tb_dcache_mem #(.FILL_KEY(FILL_KEY)) i_mem (
		.CLK(CLK),
		.nRST(nRST),
		.mem(mem),
		.dwait(dwait),
		.dload(dload)
	);

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic dcache_pkg::word_t make_addr(input dcache_pkg::tag_t t,
			input dcache_pkg::idx_t s, input logic w);
		return {t, s, w, 2'b00};
	endfunction

	function automatic expect_t ref_access(input logic wen, input dcache_pkg::word_t addr,
			input dcache_pkg::word_t wdata);
		expect_t e;
		dcache_pkg::tag_t t;
		dcache_pkg::idx_t s;
		logic w;
		t = addr[31:`DC_TAG_LSB];
		s = addr[`DC_TAG_LSB-1:`DC_IDX_LSB];
		e.read = !wen;
		e.hit = 1'b1;
		if (ref_valid[0][s] && ref_tag[0][s] == t) begin
			w = 1'b0;
		end else if (ref_valid[1][s] && ref_tag[1][s] == t) begin
			w = 1'b1;
		end else begin
			e.hit = 1'b0;
			if (!ref_valid[0][s]) begin
				w = 1'b0;
			end else if (!ref_valid[1][s]) begin
				w = 1'b1;
			end else begin
				w = ref_lru[s];
			end
			ref_valid[w][s] = 1'b1;
			ref_tag[w][s] = t;
		end
		ref_lru[s] = ~w; // other way goes next
		if (e.hit) begin
			ref_hits = ref_hits + 32'd1;
		end else begin
			ref_misses = ref_misses + 32'd1;
		end
		if (wen) begin
			ref_img[addr[13:2]] = wdata;
		end
		e.data = ref_img[addr[13:2]];
		return e;
	endfunction

	// drives at a rising edge and returns on the edge after the hit cycle
	task automatic run_access(input logic wen, input dcache_pkg::word_t addr,
			input dcache_pkg::word_t wdata, output logic dut_hit);
		expect_t e;
		e = ref_access(wen, addr, wdata);
		exp_q.push_back(e);
		req <= {!wen, wen, addr, wdata};
		@(negedge CLK);
		dut_hit = rsp.hit; // hit in the request's own cycle
		while (!rsp.hit) begin
			@(negedge CLK);
		end
		@(posedge CLK);
	endtask

	always @(posedge CLK) begin
		cycles <= cycles + 1;
		if (cycles >= CYCLE_LIMIT) begin
			$display("timeout: no progress within %0d cycles, %0d errors so far", cycles, errors);
			$display("*** FAILED ***");
			$finish;
		end
	end

	// hit class follows from the cycles spent waiting
	always @(negedge CLK) begin
		expect_t e;
		if (nRST && (req.ren || req.wen)) begin
			if (!rsp.hit) begin
				waited = waited + 1;
			end else if (exp_q.size() == 0) begin
				errors++;
				$display("response seen at %h with no request outstanding", req.addr);
			end else begin
				e = exp_q.pop_front();
				checks++;
				assert (e.hit == (waited == 0)) else begin
					errors++;
					$display("FAIL %s hit at %h: expected %0d, got %0d",
						test_name, req.addr, e.hit, waited == 0);
				end
				if (e.read) begin
					assert (rsp.rdata === e.data) else begin
						errors++;
						$display("FAIL %s read %h: expected %h, got %h",
							test_name, req.addr, e.data, rsp.rdata);
					end
				end
				waited = 0;
			end
		end
	end

	initial begin
		logic got_hit;
		logic [7:0] tsel;
		dcache_pkg::word_t a;
		int n;
		nRST = 1'b0;
		req = '0;
		halt = 1'b0;
		rng = 32'd16508;
		for (n = 0; n < 4096; n++) begin
			ref_img[n] = (n * 4) ^ FILL_KEY;
		end
		for (n = 0; n < `DC_SETS; n++) begin
			ref_valid[0][n] = 1'b0;
			ref_valid[1][n] = 1'b0;
			ref_lru[n] = 1'b0;
		end
		repeat (8) @(posedge CLK);
		nRST <= 1'b1;
		@(negedge CLK);
		assert (!rsp.hit && !mem.ren && !mem.wen && !flushed) else begin
			errors++;
			$display("outputs not idle after reset");
		end
		@(posedge CLK);

		test_name = "read";
		run_access(1'b0, make_addr(26'h10, 3'd1, 1'b0), '0, got_hit);
		run_access(1'b0, make_addr(26'h10, 3'd1, 1'b0), '0, got_hit);
		run_access(1'b0, make_addr(26'h10, 3'd1, 1'b1), '0, got_hit);
		run_access(1'b0, make_addr(26'h11, 3'd2, 1'b1), '0, got_hit);
		run_access(1'b0, make_addr(26'h11, 3'd2, 1'b1), '0, got_hit);

		test_name = "write";
		run_access(1'b1, make_addr(26'h10, 3'd1, 1'b1), 32'hdead_0001, got_hit);
		run_access(1'b0, make_addr(26'h10, 3'd1, 1'b1), '0, got_hit);
		run_access(1'b1, make_addr(26'h12, 3'd3, 1'b0), 32'hdead_0002, got_hit);
		run_access(1'b0, make_addr(26'h12, 3'd3, 1'b0), '0, got_hit);
		run_access(1'b0, make_addr(26'h12, 3'd3, 1'b1), '0, got_hit);

		// A, B, A, C in set 5; C pushes out the dirty B
		test_name = "lru";
		run_access(1'b0, make_addr(26'h20, 3'd5, 1'b0), '0, got_hit);
		run_access(1'b1, make_addr(26'h21, 3'd5, 1'b1), 32'hb0b0_0001, got_hit);
		run_access(1'b0, make_addr(26'h20, 3'd5, 1'b0), '0, got_hit);
		run_access(1'b0, make_addr(26'h22, 3'd5, 1'b0), '0, got_hit);
		a = make_addr(26'h21, 3'd5, 1'b1);
		assert (i_mem.words[a[13:2]] === 32'hb0b0_0001) else begin
			errors++;
			$display("FAIL lru writeback: expected %h, got %h", 32'hb0b0_0001,
				i_mem.words[a[13:2]]);
		end
		run_access(1'b0, make_addr(26'h20, 3'd5, 1'b0), '0, got_hit);
		assert (got_hit) else begin
			errors++;
			$display("FAIL lru A: expected hit 1, got %0d", got_hit);
		end
		run_access(1'b0, make_addr(26'h21, 3'd5, 1'b1), '0, got_hit);
		assert (!got_hit) else begin
			errors++;
			$display("FAIL lru B: expected hit 0, got %0d", got_hit);
		end

		test_name = "random";
		for (n = 0; n < 300; n++) begin
			rng = xorshift32(rng);
			tsel = rng[15:8] % 8'd6;
			a = make_addr(26'h10 + tsel, rng[2:0], rng[3]);
			got_hit = rng[20]; // write select
			rng = xorshift32(rng);
			run_access(got_hit, a, rng, got_hit);
		end

		test_name = "flush";
		req <= '0;
		halt <= 1'b1;
		@(negedge CLK);
		while (!flushed) begin
			@(negedge CLK);
		end
		for (n = 0; n < 4096; n++) begin
			if (n != (`DC_STAT_ADDR >> 2)) begin
				assert (i_mem.words[n] === ref_img[n]) else begin
					errors++;
					$display("FAIL flush word %h: expected %h, got %h",
						n * 4, ref_img[n], i_mem.words[n]);
				end
			end
		end
		assert (i_mem.words[`DC_STAT_ADDR >> 2] === ref_hits - ref_misses) else begin
			errors++;
			$display("FAIL flush stats: expected %h, got %h", ref_hits - ref_misses,
				i_mem.words[`DC_STAT_ADDR >> 2]);
		end
		repeat (4) begin
			@(negedge CLK);
			assert (flushed) else begin
				errors++;
				$display("flushed dropped after the flush had finished");
			end
		end

		$display("%0d responses checked, %0d errors", checks, errors);
		if (errors == 0) begin
			$display("*** PASSED ***");
		end else begin
			$display("*** FAILED ***");
		end
		$finish;
	end

endmodule

// File: dcache.f
+incdir+.
dcache_pkg.sv
dcache_ways.sv
dcache_ctrl.sv
dcache.sv
tb_dcache_mem.sv
tb_dcache.sv
